//--- umi_pkg.sv
package umi_pkg;

   typedef logic [31:0] cmd_t;                   // UMI command word
   typedef logic [31:0] addr_t;                  // Packet address
   typedef logic [31:0] data_t;                  // One data word
   typedef logic [4:0]  opcode_t;                // Command opcode
   typedef logic [7:0]  atype_t;                 // Atomic type, shares bits with len
   typedef logic [1:0]  err_t;                   // Response error code
   typedef logic [4:0]  hostid_t;                // Host identifier
   typedef logic [15:0] cnt_t;                   // Status counter
   typedef logic [1:0]  cfg_addr_t;              // Register address

   // Request opcodes are odd, response opcodes even
   localparam opcode_t OPC_REQ_READ   = 5'd1;
   localparam opcode_t OPC_REQ_WRITE  = 5'd3;
   localparam opcode_t OPC_REQ_POSTED = 5'd5;
   localparam opcode_t OPC_REQ_ATOMIC = 5'd9;
   localparam opcode_t OPC_RESP_READ  = 5'd2;
   localparam opcode_t OPC_RESP_WRITE = 5'd4;

   localparam atype_t AT_ADD  = 8'h00;
   localparam atype_t AT_AND  = 8'h01;
   localparam atype_t AT_OR   = 8'h02;
   localparam atype_t AT_XOR  = 8'h03;
   localparam atype_t AT_SWAP = 8'h08;

   localparam err_t ERR_OK    = 2'd0;
   localparam err_t ERR_SLAVE = 2'd2;            // Target side error

   localparam logic [2:0] SIZE_WORD = 3'd2;      // 4 bytes per transfer

   // Memory window
   localparam int unsigned MEM_WORDS = 64;
   localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);
   localparam addr_t       MEM_BASE  = 32'h0000_1000;          // Byte address of word 0
   localparam addr_t       MEM_LIMIT = MEM_BASE + addr_t'(MEM_WORDS * 4);  // First byte past end

   // Credit pools
   localparam int unsigned RX_DEPTH    = 4;      // Request credits
   localparam int unsigned RX_PW       = $clog2(RX_DEPTH);
   localparam int unsigned RSP_CREDITS = 4;      // Initial response credits
   localparam int unsigned CRD_W       = $clog2(RSP_CREDITS + 1);

   typedef logic [MEM_AW-1:0] mem_idx_t;         // Word index into memory
   typedef logic [RX_PW-1:0]  rx_ptr_t;          // FIFO pointer
   typedef logic [RX_PW:0]    rx_cnt_t;          // FIFO fill level, 0..RX_DEPTH
   typedef logic [CRD_W-1:0]  credit_t;          // Response credit count

   // Configuration register map
   localparam cfg_addr_t REG_CTRL    = 2'd0;     // Bit 0 enable
   localparam cfg_addr_t REG_REQ_CNT = 2'd1;     // Executed requests
   localparam cfg_addr_t REG_ERR_CNT = 2'd2;     // Error responses and drops

endpackage

//--- umi_decode.sv
`timescale 1ns/1ps

module umi_decode (
   input  umi_pkg::cmd_t command,                // Raw command word
   output logic          cmd_request,
   output logic          cmd_response,
   output logic          cmd_read,
   output logic          cmd_write,
   output logic          cmd_write_posted,
   output logic          cmd_atomic,
   output logic          cmd_invalid
);

   import umi_pkg::*;

   opcode_t opcode;

   assign opcode = command[4:0];                 // Opcode in low five bits

   // Direction from opcode parity
   assign cmd_request  = opcode[0];
   assign cmd_response = ~opcode[0] & (opcode != '0);  // Zero is not a response

   // Supported request kinds
   assign cmd_read         = (opcode == OPC_REQ_READ);
   assign cmd_write        = (opcode == OPC_REQ_WRITE);
   assign cmd_write_posted = (opcode == OPC_REQ_POSTED);  // No response wanted
   assign cmd_atomic       = (opcode == OPC_REQ_ATOMIC);  // Type in atype field

   // Anything else, responses included, is not served here
   assign cmd_invalid = ~(cmd_read | cmd_write | cmd_write_posted | cmd_atomic);

endmodule

//--- umi_unpack.sv
`timescale 1ns/1ps

module umi_unpack (
   input  umi_pkg::cmd_t    packet_cmd,
   output umi_pkg::opcode_t cmd_opcode,
   output logic [2:0]       cmd_size,
   output logic [7:0]       cmd_len,
   output umi_pkg::atype_t  cmd_atype,
   output logic             cmd_eom,
   output logic [1:0]       cmd_user,
   output umi_pkg::err_t    cmd_err,
   output umi_pkg::hostid_t cmd_hostid,
   output logic             cmd_read,
   output logic             cmd_write,
   output logic             cmd_write_posted,
   output logic             cmd_atomic,
   output logic             cmd_invalid
);

   logic cmd_response;                           // Qualifies the err field

   umi_decode u_decode (
      .command          (packet_cmd),
      .cmd_request      (),
      .cmd_response     (cmd_response),
      .cmd_read         (cmd_read),
      .cmd_write        (cmd_write),
      .cmd_write_posted (cmd_write_posted),
      .cmd_atomic       (cmd_atomic),
      .cmd_invalid      (cmd_invalid)
   );

   // Field layout per UMI command format
   assign cmd_opcode = packet_cmd[4:0];
   assign cmd_size   = packet_cmd[7:5];          // log2 of bytes
   assign cmd_len    = packet_cmd[15:8];         // Beats minus one
   assign cmd_atype  = packet_cmd[15:8];         // Same bits as len on atomics
   assign cmd_eom    = packet_cmd[22];
   assign cmd_user   = packet_cmd[26:25];        // Requests only
   assign cmd_hostid = packet_cmd[31:27];

   assign cmd_err = cmd_response ? packet_cmd[26:25] : 2'd0;  // User bits on requests

endmodule

//--- umi_rx_fifo.sv
`timescale 1ns/1ps

module umi_rx_fifo (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           req_valid,
   input  umi_pkg::cmd_t  req_cmd,
   input  umi_pkg::addr_t req_dstaddr,
   input  umi_pkg::addr_t req_srcaddr,
   input  umi_pkg::data_t req_data,
   input  logic           pop,
   output logic           head_valid,
   output umi_pkg::cmd_t  head_cmd,
   output umi_pkg::addr_t head_dstaddr,
   output umi_pkg::addr_t head_srcaddr,
   output umi_pkg::data_t head_data,
   output logic           req_credit
);

   import umi_pkg::*;

   cmd_t    cmd_q  [RX_DEPTH];                   // Entry storage
   addr_t   dst_q  [RX_DEPTH];
   addr_t   src_q  [RX_DEPTH];
   data_t   data_q [RX_DEPTH];
   rx_ptr_t wr_ptr;
   rx_ptr_t rd_ptr;
   rx_cnt_t count;
   logic    full;
   logic    push;

   assign full       = (count == rx_cnt_t'(RX_DEPTH));
   assign push       = req_valid & ~full;        // Credit rule keeps full pushes away
   assign head_valid = (count != '0);            // Visible one cycle after push

   assign head_cmd     = cmd_q[rd_ptr];
   assign head_dstaddr = dst_q[rd_ptr];
   assign head_srcaddr = src_q[rd_ptr];
   assign head_data    = data_q[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         cmd_q[wr_ptr]  <= req_cmd;
         dst_q[wr_ptr]  <= req_dstaddr;
         src_q[wr_ptr]  <= req_srcaddr;
         data_q[wr_ptr] <= req_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         req_credit <= 1'b0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;      // Power of two depth, wraps
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;             // Idle or push with pop
         endcase
         req_credit <= pop;                      // One credit back per pop
      end
   end

endmodule

//--- umi_mem_target.sv
`timescale 1ns/1ps

module umi_mem_target (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           head_valid,
   input  umi_pkg::cmd_t  head_cmd,
   input  umi_pkg::addr_t head_dstaddr,
   input  umi_pkg::addr_t head_srcaddr,
   input  umi_pkg::data_t head_data,
   output logic           pop,
   input  logic           enable,
   input  logic           rsp_credit,
   output logic           rsp_valid,
   output umi_pkg::cmd_t  rsp_cmd,
   output umi_pkg::addr_t rsp_dstaddr,
   output umi_pkg::data_t rsp_data,
   output logic           done_pulse,
   output logic           err_pulse
);

   import umi_pkg::*;

   logic [2:0] cmd_size;
   logic [7:0] cmd_len;
   atype_t     cmd_atype;
   hostid_t    cmd_hostid;
   logic       cmd_read;
   logic       cmd_write;
   logic       cmd_write_posted;
   logic       cmd_atomic;
   logic       cmd_invalid;

   data_t      mem [MEM_WORDS];                  // Register array, no reset
   addr_t      offset;
   mem_idx_t   idx;
   logic       in_range;
   logic       atype_ok;
   logic       bad;
   logic       issue;
   data_t      old_word;
   data_t      atomic_word;
   err_t       err_code;
   opcode_t    rsp_opcode;
   credit_t    credit_cnt;

   umi_unpack u_unpack (
      .packet_cmd       (head_cmd),
      .cmd_opcode       (),
      .cmd_size         (cmd_size),
      .cmd_len          (cmd_len),
      .cmd_atype        (cmd_atype),
      .cmd_eom          (),
      .cmd_user         (),
      .cmd_err          (),
      .cmd_hostid       (cmd_hostid),
      .cmd_read         (cmd_read),
      .cmd_write        (cmd_write),
      .cmd_write_posted (cmd_write_posted),
      .cmd_atomic       (cmd_atomic),
      .cmd_invalid      (cmd_invalid)
   );

   // Address window check and word index
   assign offset   = head_dstaddr - MEM_BASE;
   assign in_range = (head_dstaddr >= MEM_BASE) && (head_dstaddr < MEM_LIMIT);
   assign idx      = offset[MEM_AW+1:2];         // Byte lanes dropped
   assign old_word = mem[idx];                   // Combinational read

   assign atype_ok = (cmd_atype == AT_ADD) || (cmd_atype == AT_AND) || (cmd_atype == AT_OR) ||
                     (cmd_atype == AT_XOR) || (cmd_atype == AT_SWAP);

   always_comb begin
      case (cmd_atype)
         AT_ADD:  atomic_word = old_word + head_data;
         AT_AND:  atomic_word = old_word & head_data;
         AT_OR:   atomic_word = old_word | head_data;
         AT_XOR:  atomic_word = old_word ^ head_data;
         AT_SWAP: atomic_word = head_data;
         default: atomic_word = old_word;        // Unsupported, flagged by bad
      endcase
   end

   // Single word only; len bits carry atype on atomics
   assign bad = cmd_invalid | (cmd_size != SIZE_WORD) | (~cmd_atomic & (cmd_len != 8'd0)) |
                (cmd_atomic & ~atype_ok) | ~in_range;
   assign err_code   = bad ? ERR_SLAVE : ERR_OK;
   assign rsp_opcode = (cmd_read | cmd_atomic) ? OPC_RESP_READ : OPC_RESP_WRITE;

   // Posted writes need no response credit
   assign pop        = head_valid & enable & (cmd_write_posted | (credit_cnt != '0));
   assign issue      = pop & ~cmd_write_posted;
   assign done_pulse = pop;                      // Dropped posted writes included
   assign err_pulse  = pop & bad;

   always_ff @(posedge clk) begin
      if (pop && !bad) begin
         if (cmd_write || cmd_write_posted) begin
            mem[idx] <= head_data;
         end else if (cmd_atomic) begin
            mem[idx] <= atomic_word;             // Read-modify-write in one edge
         end
      end
   end

   // Response payload
   always_ff @(posedge clk) begin
      if (issue) begin
         rsp_cmd     <= {cmd_hostid, err_code, 9'd0, cmd_len, cmd_size, rsp_opcode};
         rsp_dstaddr <= head_srcaddr;            // Back to the requester
         rsp_data    <= (!bad && (cmd_read || cmd_atomic)) ? old_word : '0;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_valid  <= 1'b0;
         credit_cnt <= credit_t'(RSP_CREDITS);
      end else begin
         rsp_valid <= issue;                     // One cycle per response
         case ({issue, rsp_credit})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;  // Spent at pop
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

endmodule

//--- umi_regs.sv
`timescale 1ns/1ps

module umi_regs (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               cfg_we,
   input  umi_pkg::cfg_addr_t cfg_addr,
   input  umi_pkg::data_t     cfg_wdata,
   output umi_pkg::data_t     cfg_rdata,
   input  logic               done_pulse,
   input  logic               err_pulse,
   output logic               enable
);

   import umi_pkg::*;

   cnt_t req_cnt;                                // Executed requests
   cnt_t err_cnt;                                // Error responses and drops
   logic wr_ctrl;
   logic wr_req;
   logic wr_err;

   assign wr_ctrl = cfg_we && (cfg_addr == REG_CTRL);
   assign wr_req  = cfg_we && (cfg_addr == REG_REQ_CNT);
   assign wr_err  = cfg_we && (cfg_addr == REG_ERR_CNT);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         enable  <= 1'b0;
         req_cnt <= '0;
         err_cnt <= '0;
      end else begin
         if (wr_ctrl) enable <= cfg_wdata[0];    // Other bits ignored

         // Any write clears, clear beats a same-cycle event
         if (wr_req) begin
            req_cnt <= '0;
         end else if (done_pulse && (req_cnt != '1)) begin
            req_cnt <= req_cnt + 1'b1;           // Saturates at all ones
         end

         if (wr_err) begin
            err_cnt <= '0;
         end else if (err_pulse && (err_cnt != '1)) begin
            err_cnt <= err_cnt + 1'b1;
         end
      end
   end

   // Read mux, no wait state
   always_comb begin
      case (cfg_addr)
         REG_CTRL:    cfg_rdata = {31'd0, enable};
         REG_REQ_CNT: cfg_rdata = {16'd0, req_cnt};
         REG_ERR_CNT: cfg_rdata = {16'd0, err_cnt};
         default:     cfg_rdata = '0;            // Unmapped
      endcase
   end

endmodule

//--- umi_endpoint_top.sv
`timescale 1ns/1ps

module umi_endpoint_top (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               req_valid,        // Request side
   input  umi_pkg::cmd_t      req_cmd,
   input  umi_pkg::addr_t     req_dstaddr,
   input  umi_pkg::addr_t     req_srcaddr,
   input  umi_pkg::data_t     req_data,
   output logic               req_credit,
   output logic               rsp_valid,        // Response side
   output umi_pkg::cmd_t      rsp_cmd,
   output umi_pkg::addr_t     rsp_dstaddr,
   output umi_pkg::data_t     rsp_data,
   input  logic               rsp_credit,
   input  logic               cfg_we,           // Configuration port
   input  umi_pkg::cfg_addr_t cfg_addr,
   input  umi_pkg::data_t     cfg_wdata,
   output umi_pkg::data_t     cfg_rdata
);

   import umi_pkg::*;

   logic  head_valid;                            // FIFO head
   cmd_t  head_cmd;
   addr_t head_dstaddr;
   addr_t head_srcaddr;
   data_t head_data;
   logic  pop;
   logic  enable;
   logic  done_pulse;
   logic  err_pulse;

   umi_rx_fifo u_rx_fifo (
      .clk          (clk),
      .arst_n       (arst_n),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .pop          (pop),
      .head_valid   (head_valid),
      .head_cmd     (head_cmd),
      .head_dstaddr (head_dstaddr),
      .head_srcaddr (head_srcaddr),
      .head_data    (head_data),
      .req_credit   (req_credit)
   );

   umi_mem_target u_mem_target (
      .clk          (clk),
      .arst_n       (arst_n),
      .head_valid   (head_valid),
      .head_cmd     (head_cmd),
      .head_dstaddr (head_dstaddr),
      .head_srcaddr (head_srcaddr),
      .head_data    (head_data),
      .pop          (pop),
      .enable       (enable),
      .rsp_credit   (rsp_credit),
      .rsp_valid    (rsp_valid),
      .rsp_cmd      (rsp_cmd),
      .rsp_dstaddr  (rsp_dstaddr),
      .rsp_data     (rsp_data),
      .done_pulse   (done_pulse),
      .err_pulse    (err_pulse)
   );

   umi_regs u_regs (
      .clk        (clk),
      .arst_n     (arst_n),
      .cfg_we     (cfg_we),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .cfg_rdata  (cfg_rdata),
      .done_pulse (done_pulse),
      .err_pulse  (err_pulse),
      .enable     (enable)
   );

endmodule

//--- tb_umi_endpoint.sv
`timescale 1ns/1ps

module tb_umi_endpoint;

   import umi_pkg::*;

   localparam int          WAIT_LIMIT = 500;      // Cycles allowed per wait loop
   localparam logic [31:0] SEED       = 32'h6767_901b;

   logic      clk;
   logic      arst_n;
   logic      req_valid;
   cmd_t      req_cmd;
   addr_t     req_dstaddr;
   addr_t     req_srcaddr;
   data_t     req_data;
   logic      req_credit;
   logic      rsp_valid;
   cmd_t      rsp_cmd;
   addr_t     rsp_dstaddr;
   data_t     rsp_data;
   logic      rsp_credit;
   logic      cfg_we;
   cfg_addr_t cfg_addr;
   data_t     cfg_wdata;
   data_t     cfg_rdata;

   data_t       ref_mem [MEM_WORDS];              // Reference memory
   cmd_t        exp_cmd_q [$];                    // Expected responses in order
   addr_t       exp_dst_q [$];
   data_t       exp_data_q [$];
   int          exp_cyc_q [$];                    // Arrival cycle, -1 unchecked
   int          value_errs    = 0;
   int          other_errs    = 0;
   int          cyc           = 0;
   int          req_credits   = RX_DEPTH;         // Sender credit pool
   int          credit_pulses = 0;
   int          accepted      = 0;
   int          owed          = 0;                // Responses held by the sink
   int          rsp_seen      = 0;
   int          model_req_cnt = 0;
   int          model_err_cnt = 0;
   logic        withhold      = 1'b0;             // Sink keeps its credits
   logic [31:0] rng           = SEED;
   logic [31:0] sink_rng      = SEED;

   umi_endpoint_top dut_i (.*);

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic cmd_t make_cmd(input opcode_t opc, input logic [2:0] size,
                                     input logic [7:0] len, input hostid_t host);
      return {host, 2'b00, 9'd0, len, size, opc};  // User and eom zero
   endfunction

   function automatic void check_word(input string name, input logic [31:0] got,
                                      input logic [31:0] exp);
      assert (got === exp) else begin
         value_errs++;
         $display("Error %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endfunction

   // Applies one request to the model and queues its response
   function automatic void model_request(input cmd_t cmd, input addr_t dst, input addr_t src,
                                         input data_t data, input int due);
      opcode_t    opc;
      logic [7:0] len;
      logic       is_rd;
      logic       is_at;
      logic       ok;
      int         w;
      data_t      old;
      opc   = cmd[4:0];
      len   = cmd[15:8];
      is_rd = (opc == OPC_REQ_READ);
      is_at = (opc == OPC_REQ_ATOMIC);
      ok    = (is_rd || is_at || opc == OPC_REQ_WRITE || opc == OPC_REQ_POSTED);
      ok    = ok && (cmd[7:5] == 3'd2);           // Word transfers only
      ok    = ok && (is_at ? (len == AT_ADD || len == AT_AND || len == AT_OR ||
                              len == AT_XOR || len == AT_SWAP) : (len == 8'd0));
      ok    = ok && (dst >= MEM_BASE) && (dst < MEM_BASE + MEM_WORDS * 4);
      w     = ok ? int'((dst - MEM_BASE) >> 2) : 0;
      old   = ref_mem[w];
      model_req_cnt++;
      if (!ok) model_err_cnt++;
      if (ok && (opc == OPC_REQ_WRITE || opc == OPC_REQ_POSTED)) ref_mem[w] = data;
      if (ok && is_at) begin
         case (len)
            AT_ADD:  ref_mem[w] = old + data;
            AT_AND:  ref_mem[w] = old & data;
            AT_OR:   ref_mem[w] = old | data;
            AT_XOR:  ref_mem[w] = old ^ data;
            default: ref_mem[w] = data;           // Swap
         endcase
      end
      if (opc != OPC_REQ_POSTED) begin
         exp_cmd_q.push_back({cmd[31:27], ok ? ERR_OK : ERR_SLAVE, 9'd0, len, cmd[7:5],
                              (is_rd || is_at) ? OPC_RESP_READ : OPC_RESP_WRITE});
         exp_dst_q.push_back(src);                // Reply goes to srcaddr
         exp_data_q.push_back((ok && (is_rd || is_at)) ? old : 32'd0);
         exp_cyc_q.push_back(due);
      end
   endfunction

   // Called and returns on a falling edge
   task automatic send_req(input cmd_t cmd, input addr_t dst, input addr_t src,
                           input data_t data, input bit idle);
      int n;
      n = 0;
      while (req_credits == 0 && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      assert (req_credits > 0) else begin
         other_errs++;
         $display("Error %0t: no request credit came back in time", $time);
      end
      req_valid   = 1'b1;
      req_cmd     = cmd;
      req_dstaddr = dst;
      req_srcaddr = src;
      req_data    = data;
      req_credits--;
      accepted++;
      model_request(cmd, dst, src, data, idle ? cyc + 2 : -1);  // Two cycles from idle
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_cmd_q.size() != 0 || req_credits != RX_DEPTH || owed != 0) &&
             n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      assert (exp_cmd_q.size() == 0 && req_credits == RX_DEPTH && owed == 0) else begin
         other_errs++;
         $display("Error %0t: responses or credits still outstanding after timeout", $time);
      end
   endtask

   task automatic write_reg(input cfg_addr_t a, input data_t d);
      cfg_we    = 1'b1;
      cfg_addr  = a;
      cfg_wdata = d;
      @(negedge clk);
      cfg_we = 1'b0;
   endtask

   task automatic check_reg(input cfg_addr_t a, input int exp, input string name);
      cfg_addr = a;
      @(posedge clk);                             // Read data settled mid cycle
      check_word(name, cfg_rdata, data_t'(exp));
      @(negedge clk);
   endtask

   // Outputs sampled on the rising edge, before they update
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (arst_n && req_credit) begin
         req_credits++;
         credit_pulses++;
      end
      if (arst_n && rsp_valid) begin
         owed++;
         rsp_seen++;
         if (exp_cmd_q.size() == 0) begin
            other_errs++;
            $display("Error %0t: a response arrived when none was expected", $time);
         end else begin : match_rsp
            int due;
            check_word("rsp_cmd", rsp_cmd, exp_cmd_q.pop_front());
            check_word("rsp_dstaddr", rsp_dstaddr, exp_dst_q.pop_front());
            check_word("rsp_data", rsp_data, exp_data_q.pop_front());
            due = exp_cyc_q.pop_front();
            if (due >= 0) check_word("rsp_valid cycle", cyc, due);
         end
      end
   end

   // Sink returns credits after a random delay
   always @(negedge clk) begin
      rsp_credit = 1'b0;
      sink_rng   = xorshift(sink_rng);
      if (arst_n && !withhold && owed > 0 && sink_rng[1:0] == 2'd0) begin
         rsp_credit = 1'b1;
         owed--;
      end
   end

   assert property (@(posedge clk) disable iff (!arst_n) owed <= int'(RSP_CREDITS))
      else begin
         other_errs++;
         $display("Error %0t: sink holds more responses than response credits", $time);
      end

   assert property (@(posedge clk) disable iff (!arst_n)
                    (req_credits >= 0) && (req_credits <= int'(RX_DEPTH)))
      else begin
         other_errs++;
         $display("Error %0t: request credit count left its legal range", $time);
      end

   initial begin : main
      addr_t  a;
      data_t  d;
      int     seen;
      atype_t ops [5];
      ops         = '{AT_ADD, AT_AND, AT_OR, AT_XOR, AT_SWAP};
      clk         = 1'b0;
      arst_n      = 1'b0;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      rsp_credit  = 1'b0;
      cfg_we      = 1'b0;
      cfg_addr    = '0;
      cfg_wdata   = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // Disabled target leaves the request in the FIFO
      send_req(make_cmd(OPC_REQ_WRITE, 3'd2, 8'd0, 5'd3), MEM_BASE + 32'h14, 32'h8000_0000,
               32'hdead_beef, 1'b0);
      repeat (10) @(negedge clk);                 // Window for a wrong response
      check_word("responses while disabled", rsp_seen, 0);
      check_word("request credits while disabled", req_credits, RX_DEPTH - 1);
      write_reg(REG_CTRL, 32'd1);
      wait_drain();

      // Fill every word, posted, back to back
      for (int w = 0; w < MEM_WORDS; w++) begin
         a = MEM_BASE + addr_t'(w * 4);
         send_req(make_cmd(OPC_REQ_POSTED, 3'd2, 8'd0, 5'd0), a, 32'h0,
                  (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f, 1'b0);
      end
      wait_drain();

      // Random write then read, each from idle
      for (int i = 0; i < 8; i++) begin
         rng = xorshift(rng);
         a   = MEM_BASE + addr_t'({rng[5:0], 2'b00});
         rng = xorshift(rng);
         d   = rng;
         send_req(make_cmd(OPC_REQ_WRITE, 3'd2, 8'd0, d[20:16]), a, {d[15:0], 16'h0}, d, 1'b1);
         wait_drain();
         send_req(make_cmd(OPC_REQ_READ, 3'd2, 8'd0, d[24:20]), a, ~d, 32'h0, 1'b1);
         wait_drain();
      end

      // Each atomic type followed by a read back
      for (int i = 0; i < 5; i++) begin
         rng = xorshift(rng);
         a   = MEM_BASE + addr_t'({rng[5:0], 2'b00});
         rng = xorshift(rng);
         send_req(make_cmd(OPC_REQ_ATOMIC, 3'd2, ops[i], 5'd9), a, 32'h4000, rng, 1'b0);
         send_req(make_cmd(OPC_REQ_READ, 3'd2, 8'd0, 5'd9), a, 32'h4004, 32'h0, 1'b0);
      end
      wait_drain();

      // Posted write lands, out of range one is dropped and counted
      send_req(make_cmd(OPC_REQ_POSTED, 3'd2, 8'd0, 5'd1), MEM_BASE + 32'h20, 32'h0,
               32'h1234_5678, 1'b0);
      send_req(make_cmd(OPC_REQ_READ, 3'd2, 8'd0, 5'd1), MEM_BASE + 32'h20, 32'h20, 0, 1'b0);
      wait_drain();
      check_reg(REG_ERR_CNT, model_err_cnt, "REG_ERR_CNT");
      send_req(make_cmd(OPC_REQ_POSTED, 3'd2, 8'd0, 5'd1), MEM_BASE + 32'h100, 32'h0,
               32'h0bad_0bad, 1'b0);
      wait_drain();
      check_reg(REG_ERR_CNT, model_err_cnt, "REG_ERR_CNT");

      // Error responses, memory untouched
      a = MEM_BASE + 32'h30;
      send_req(make_cmd(OPC_REQ_WRITE, 3'd3, 8'd0, 5'd1), a, 32'h1, 32'hffff_ffff, 1'b0);
      send_req(make_cmd(OPC_REQ_WRITE, 3'd2, 8'd1, 5'd2), a, 32'h2, 32'hffff_ffff, 1'b0);
      send_req(make_cmd(5'd7, 3'd2, 8'd0, 5'd3), a, 32'h3, 32'hffff_ffff, 1'b0);
      send_req(make_cmd(OPC_REQ_ATOMIC, 3'd2, 8'h05, 5'd4), a, 32'h4, 32'hffff_ffff, 1'b0);
      send_req(make_cmd(OPC_REQ_READ, 3'd2, 8'd0, 5'd5), MEM_BASE - 32'd4, 32'h5, 0, 1'b0);
      send_req(make_cmd(OPC_REQ_WRITE, 3'd2, 8'd0, 5'd6), MEM_BASE + 32'h100, 32'h6, 0, 1'b0);
      send_req(make_cmd(OPC_REQ_READ, 3'd2, 8'd0, 5'd7), a, 32'h7, 32'h0, 1'b0);
      wait_drain();

      // Sink withholds credits, two requests stall at the head
      withhold = 1'b1;
      seen     = rsp_seen;
      for (int i = 0; i < 6; i++) begin
         send_req(make_cmd(OPC_REQ_READ, 3'd2, 8'd0, 5'(i)), MEM_BASE + addr_t'(i * 4),
                  32'h6000 + addr_t'(i), 32'h0, 1'b0);
      end
      repeat (20) @(negedge clk);                 // Window for extra responses
      check_word("responses while withheld", rsp_seen - seen, RSP_CREDITS);
      check_word("request credits while blocked", req_credits, RX_DEPTH - 2);
      withhold = 1'b0;
      wait_drain();
      check_word("req_credit pulses", credit_pulses, accepted);

      // Counters match the model, then clear on write
      check_reg(REG_REQ_CNT, model_req_cnt, "REG_REQ_CNT");
      check_reg(REG_ERR_CNT, model_err_cnt, "REG_ERR_CNT");
      write_reg(REG_REQ_CNT, 32'hffff_ffff);
      write_reg(REG_ERR_CNT, 32'h0);
      model_req_cnt = 0;
      model_err_cnt = 0;
      check_reg(REG_REQ_CNT, model_req_cnt, "REG_REQ_CNT");
      check_reg(REG_ERR_CNT, model_err_cnt, "REG_ERR_CNT");

      $display("Error counts: %0d wrong values, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- list.f
umi_pkg.sv
umi_decode.sv
umi_unpack.sv
umi_rx_fifo.sv
umi_mem_target.sv
umi_regs.sv
umi_endpoint_top.sv
tb_umi_endpoint.sv

//--- Bender.yml
package:
  name: umi_endpoint

sources:
  - umi_pkg.sv
  - umi_decode.sv
  - umi_unpack.sv
  - umi_rx_fifo.sv
  - umi_mem_target.sv
  - umi_regs.sv
  - umi_endpoint_top.sv
  - target: test
    files:
      - tb_umi_endpoint.sv
